//--- verilog/gb80_pkg.sv
package gb80_pkg;

   // Basic widths
   typedef logic [15:0] addr_t;
   typedef logic [7:0]  byte_t;

   // Interrupt sources with bit 0 as highest priority
   // vblank, lcdc, timer, serial, joypad
   typedef logic [4:0] irq_bits_t;
   typedef logic [2:0] irq_index_t;

   // Offset into the high memory window
   typedef logic [6:0] hram_addr_t;

   // Request port from the test side
   typedef struct packed {
      addr_t addr;
      byte_t wdata;
      logic  we;
      logic  re;
   } bus_req_t;

   // External memory pins
   typedef struct packed {
      addr_t addr;
      byte_t wdata;
      logic  we;
      logic  re;
   } ext_bus_t;

   typedef enum logic [1:0] {state_idle, state_wait, state_ack} dispatch_state_t;

   // Address map
   localparam addr_t HRAM_START = 16'hff80;
   localparam addr_t HRAM_END   = 16'hfffe;
   localparam addr_t MMIO_IF    = 16'hff0f;
   localparam addr_t MMIO_IE    = 16'hffff;

   localparam int HRAM_DEPTH = 127;
   localparam int IRQ_COUNT  = 5;

   // Vector is VECTOR_BASE + VECTOR_STEP * index
   localparam addr_t VECTOR_BASE = 16'h0040;
   localparam int    VECTOR_STEP = 8;

   // Dispatch timing
   localparam int DISPATCH_WAIT = 3;
   localparam int TIMER_WIDTH   = 2;

endpackage

//--- verilog/memory_bus.sv
`timescale 1ns/10ps

module memory_bus import gb80_pkg::*; (
   input  logic       clock,
   input  logic       reset,
   input  bus_req_t   request,
   input  logic       mem_disable,
   input  byte_t      ext_rdata,
   output ext_bus_t   ext,
   output logic       hram_we,
   output hram_addr_t hram_addr,
   output byte_t      hram_wdata,
   input  byte_t      hram_rdata,
   output logic       if_write,
   output logic       ie_write,
   output irq_bits_t  reg_wdata,
   input  irq_bits_t  if_data,
   input  irq_bits_t  ie_data,
   output byte_t      rdata,
   output logic       rdata_valid
);

   logic  is_hram;
   logic  is_if;
   logic  is_ie;
   logic  is_ext;
   addr_t hram_offset;
   byte_t rd_source;
   byte_t rd_data_q;
   logic  rd_hram_q;

   // Address decode
   assign is_hram = (request.addr >= HRAM_START) && (request.addr <= HRAM_END);
   assign is_if   = request.addr == MMIO_IF;
   assign is_ie   = request.addr == MMIO_IE;
   assign is_ext  = !(is_hram || is_if || is_ie);

   // External pins with strobes blocked while memory is disabled
   assign ext.addr  = request.addr;
   assign ext.wdata = request.wdata;
   assign ext.we    = request.we && is_ext && !mem_disable;
   assign ext.re    = request.re && is_ext && !mem_disable;

   // High memory takes the offset from the window start
   assign hram_offset = request.addr - HRAM_START;
   assign hram_addr   = hram_offset[6:0];
   assign hram_wdata  = request.wdata;
   assign hram_we     = request.we && is_hram;

   // Interrupt register writes use the low five bits
   assign if_write  = request.we && is_if;
   assign ie_write  = request.we && is_ie;
   assign reg_wdata = request.wdata[4:0];

   // Read source for registers and external pins
   // Disabled external reads give zero
   always_comb begin
      if (is_if)
         rd_source = {3'b000, if_data};
      else if (is_ie)
         rd_source = {3'b000, ie_data};
      else if (mem_disable)
         rd_source = '0;
      else
         rd_source = ext_rdata;
   end

   // Result captured on the strobe edge
   always_ff @(posedge clock) begin
      if (request.re)
         rd_data_q <= rd_source;
   end

   // Read valid and target remembered for one cycle
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         rdata_valid <= 1'b0;
         rd_hram_q   <= 1'b0;
      end else begin
         rdata_valid <= request.re;
         rd_hram_q   <= request.re && is_hram;
      end
   end

   // HRAM already registered its byte on the same edge
   assign rdata = rd_hram_q ? hram_rdata : rd_data_q;

endmodule

//--- verilog/high_ram.sv
`timescale 1ns/10ps

module high_ram import gb80_pkg::*; (
   input  logic       clock,
   input  logic       we,
   input  hram_addr_t addr,
   input  byte_t      wdata,
   output byte_t      rdata
);

   // Contents undefined after power up
   byte_t mem [HRAM_DEPTH];

   // Synchronous write
   always_ff @(posedge clock) begin
      if (we)
         mem[addr] <= wdata;
   end

   // Registered read every cycle
   // old contents come out on a same-cycle write
   always_ff @(posedge clock) begin
      rdata <= mem[addr];
   end

endmodule

//--- verilog/irq_registers.sv
`timescale 1ns/10ps

module irq_registers import gb80_pkg::*; (
   input  logic      clock,
   input  logic      reset,
   input  irq_bits_t irq_request,
   input  logic      if_write,
   input  logic      ie_write,
   input  irq_bits_t reg_wdata,
   input  logic      ime_set,
   input  logic      ime_reset,
   input  logic      start,
   input  logic      ack,
   output logic      pending,
   output irq_bits_t if_data,
   output irq_bits_t ie_data,
   output logic      ime,
   output logic      vector_valid,
   output addr_t     vector
);

   irq_bits_t  active;
   irq_bits_t  if_next;
   irq_index_t chosen;
   irq_index_t index_q;

   // Flagged and enabled
   assign active  = if_data & ie_data;
   assign pending = ime && (active != '0);

   // Priority encoder where the lowest set bit wins
   always_comb begin
      chosen = '0;
      for (int i = IRQ_COUNT - 1; i >= 0; i--) begin
         if (active[i])
            chosen = irq_index_t'(i);
      end
   end

   // Ack clear first, then bus write, then new requests ORed in
   always_comb begin
      if_next = if_data;
      if (ack)
         if_next[index_q] = 1'b0;
      if (if_write)
         if_next = reg_wdata;
      if_next = if_next | irq_request;
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         if_data <= '0;
         ie_data <= '0;
         ime     <= 1'b0;
         index_q <= '0;
      end else begin
         if_data <= if_next;
         if (ie_write)
            ie_data <= reg_wdata;
         // Set beats reset
         // Dispatch also drops IME
         if (ime_set)
            ime <= 1'b1;
         else if (ime_reset || ack)
            ime <= 1'b0;
         // Source frozen for the whole dispatch
         if (start)
            index_q <= chosen;
      end
   end

   // Vector shown in the ack cycle
   assign vector_valid = ack;
   assign vector       = VECTOR_BASE + addr_t'(index_q) * addr_t'(VECTOR_STEP);

endmodule

//--- verilog/dispatch_fsm.sv
`timescale 1ns/10ps

module dispatch_fsm import gb80_pkg::*; (
   input  logic clock,
   input  logic reset,
   input  logic pending,
   input  logic timer_done,
   output logic start,
   output logic timer_load,
   output logic ack
);

   dispatch_state_t state;
   dispatch_state_t next_state;

   always_ff @(posedge clock or posedge reset) begin
      if (reset)
         state <= state_idle;
      else
         state <= next_state;
   end

   always_comb begin
      next_state = state;
      start      = 1'b0;
      timer_load = 1'b0;
      ack        = 1'b0;
      case (state)
         state_idle: begin
            // Latch source and arm timer in the same cycle
            if (pending) begin
               start      = 1'b1;
               timer_load = 1'b1;
               next_state = state_wait;
            end
         end
         state_wait: begin
            // Pending ignored here
            if (timer_done)
               next_state = state_ack;
         end
         state_ack: begin
            ack        = 1'b1;
            next_state = state_idle;
         end
         default: next_state = state_idle;
      endcase
   end

endmodule

//--- verilog/dispatch_timer.sv
`timescale 1ns/10ps

module dispatch_timer import gb80_pkg::*; (
   input  logic clock,
   input  logic reset,
   input  logic load,
   output logic done
);

   logic [TIMER_WIDTH-1:0] count;
   logic                   running;

   // High for one cycle at zero count while running
   assign done = running && (count == '0);

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         count   <= '0;
         running <= 1'b0;
      end else if (load) begin
         count   <= TIMER_WIDTH'(DISPATCH_WAIT - 1);
         running <= 1'b1;
      end else if (running) begin
         // Stop once zero has been shown
         if (count == '0)
            running <= 1'b0;
         else
            count <= count - 1'b1;
      end
   end

endmodule

//--- verilog/gb80_irq_top.sv
`timescale 1ns/10ps

module gb80_irq_top import gb80_pkg::*; (
   input  logic      clock,
   input  logic      reset,
   input  bus_req_t  request,
   input  logic      mem_disable,
   input  byte_t     ext_rdata,
   input  irq_bits_t irq_request,
   input  logic      ime_set,
   input  logic      ime_reset,
   output ext_bus_t  ext,
   output byte_t     rdata,
   output logic      rdata_valid,
   output logic      vector_valid,
   output addr_t     vector,
   output irq_bits_t if_data,
   output irq_bits_t ie_data,
   output logic      ime
);

   // High memory port
   logic       hram_we;
   hram_addr_t hram_addr;
   byte_t      hram_wdata;
   byte_t      hram_rdata;

   // Bus writes into IF and IE
   logic      if_write;
   logic      ie_write;
   irq_bits_t reg_wdata;

   // Dispatch handshake between registers, FSM and timer
   logic pending;
   logic start;
   logic ack;
   logic timer_load;
   logic timer_done;

   memory_bus i_bus (
      .clock, .reset, .request, .mem_disable, .ext_rdata, .ext,
      .hram_we, .hram_addr, .hram_wdata, .hram_rdata,
      .if_write, .ie_write, .reg_wdata, .if_data, .ie_data,
      .rdata, .rdata_valid
   );

   high_ram i_hram (.clock, .we(hram_we), .addr(hram_addr), .wdata(hram_wdata),
      .rdata(hram_rdata));

   irq_registers i_irq (
      .clock, .reset, .irq_request, .if_write, .ie_write, .reg_wdata,
      .ime_set, .ime_reset, .start, .ack, .pending, .if_data, .ie_data,
      .ime, .vector_valid, .vector
   );

   dispatch_fsm i_fsm (.clock, .reset, .pending, .timer_done, .start, .timer_load, .ack);

   dispatch_timer i_timer (.clock, .reset, .load(timer_load), .done(timer_done));

endmodule

//--- bench/tb_gb80_irq.sv
`timescale 1ns/10ps

module tb_gb80_irq import gb80_pkg::*; ();

   typedef enum logic [2:0] {k_write, k_read, k_irq, k_ime, k_dispatch, k_quiet} kind_t;

   // One table row
   // Expected holds the read byte, the IME level or the source index
   typedef struct packed {
      kind_t kind;
      addr_t addr;
      byte_t data;
      byte_t expected;
      logic  mem_off;
   } entry_t;

   logic      clock = 1'b0;
   logic      reset;
   bus_req_t  request;
   logic      mem_disable;
   byte_t     ext_rdata;
   irq_bits_t irq_request;
   logic      ime_set;
   logic      ime_reset;
   ext_bus_t  ext;
   byte_t     rdata;
   logic      rdata_valid;
   logic      vector_valid;
   addr_t     vector;
   irq_bits_t if_data;
   irq_bits_t ie_data;
   logic      ime;

   entry_t      entries[$];
   string       names[$];
   logic [31:0] lfsr_state = 32'hb794_61f9;
   logic        table_ready = 1'b0;
   logic        test_bad;
   int          errors = 0;
   int          failing = 0;

   gb80_irq_top i_dut (.*);

   always #10 clock = ~clock;

   // Galois LFSR shifting right
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h8020_0003;
      return s >> 1;
   endfunction

   // One step per bit taken
   function automatic logic [31:0] random_bits(input int width);
      logic [31:0] value;
      value = '0;
      for (int n = 0; n < width; n++) begin
         lfsr_state = lfsr_next(lfsr_state);
         value      = {value[30:0], lfsr_state[0]};
      end
      return value;
   endfunction

   // Anything outside high memory and both registers goes to the pins
   function automatic logic is_external(input addr_t a);
      return !((a >= HRAM_START && a <= HRAM_END) || a == MMIO_IF || a == MMIO_IE);
   endfunction

   // IME set and a source both flagged and enabled
   function automatic logic pending_level();
      return ime && ((if_data & ie_data) != '0);
   endfunction

   task automatic flag_error(input string text);
      $display("%s", text);
      errors++;
      test_bad = 1'b1;
   endtask

   task automatic check_byte(input string name, input byte_t want, input byte_t got);
      if (want !== got)
         flag_error($sformatf("ERROR %s expected %h actual %h", name, want, got));
   endtask

   task automatic check_addr(input string name, input addr_t want, input addr_t got);
      if (want !== got)
         flag_error($sformatf("ERROR %s expected %h actual %h", name, want, got));
   endtask

   task automatic check_bits(input string name, input irq_bits_t want, input irq_bits_t got);
      if (want !== got)
         flag_error($sformatf("ERROR %s expected %b actual %b", name, want, got));
   endtask

   task automatic check_flag(input string name, input logic want, input logic got);
      if (want !== got)
         flag_error($sformatf("ERROR %s expected %b actual %b", name, want, got));
   endtask

   // Address and data only matter where a strobe is due
   task automatic check_ext(input string name, input ext_bus_t want, input ext_bus_t got);
      logic bad;
      bad = (want.we !== got.we) || (want.re !== got.re);
      if (want.we || want.re)
         bad = bad || (want.addr !== got.addr);
      if (want.we)
         bad = bad || (want.wdata !== got.wdata);
      if (bad)
         flag_error($sformatf("ERROR %s ext expected %h actual %h", name, want, got));
   endtask

   task automatic add_entry(input string name, input kind_t kind, input addr_t addr,
                            input byte_t data, input byte_t expected, input logic mem_off);
      entry_t e;
      e.kind     = kind;
      e.addr     = addr;
      e.data     = data;
      e.expected = expected;
      e.mem_off  = mem_off;
      entries.push_back(e);
      names.push_back(name);
   endtask

   task automatic build_table();
      addr_t addr;
      byte_t value;
      // High memory pairs with the last two on the window edges
      for (int n = 0; n < 6; n++) begin
         if (n == 4)
            addr = HRAM_START;
         else if (n == 5)
            addr = HRAM_END;
         else
            addr = HRAM_START + addr_t'(random_bits(7) % 127);
         value = byte_t'(random_bits(8));
         add_entry($sformatf("hram_write_%0d", n), k_write, addr, value, 8'h00, 1'b0);
         add_entry($sformatf("hram_read_%0d", n), k_read, addr, 8'h00, value, 1'b0);
      end
      // External pins and then blocked by mem_disable
      add_entry("ext_write", k_write, 16'hc123, 8'h5a, 8'h00, 1'b0);
      add_entry("ext_read", k_read, 16'h8000, 8'ha7, 8'ha7, 1'b0);
      add_entry("ext_read_below_hram", k_read, 16'hff7f, 8'h3c, 8'h3c, 1'b0);
      add_entry("ext_write_disabled", k_write, 16'hc124, 8'h11, 8'h00, 1'b1);
      add_entry("ext_read_disabled", k_read, 16'h8001, 8'h99, 8'h00, 1'b1);
      // Registers keep the low five bits
      add_entry("ie_write", k_write, MMIO_IE, 8'hf6, 8'h00, 1'b0);
      add_entry("ie_read", k_read, MMIO_IE, 8'h00, 8'h16, 1'b0);
      add_entry("if_write", k_write, MMIO_IF, 8'he1, 8'h00, 1'b0);
      add_entry("if_read", k_read, MMIO_IF, 8'h00, 8'h01, 1'b0);
      add_entry("irq_request", k_irq, 16'h0000, 8'h1c, 8'h00, 1'b0);
      add_entry("if_read_ored", k_read, MMIO_IF, 8'h00, 8'h1d, 1'b0);
      // IF is 1d and IE is 16 with common bits 2 and 4
      add_entry("quiet_ime_clear", k_quiet, 16'h0000, 8'h00, 8'h00, 1'b0);
      add_entry("ime_set_1", k_ime, 16'h0000, 8'h01, 8'h01, 1'b0);
      add_entry("dispatch_timer", k_dispatch, 16'h0000, 8'h00, 8'd2, 1'b0);
      add_entry("if_read_after_ack", k_read, MMIO_IF, 8'h00, 8'h19, 1'b0);
      add_entry("quiet_after_ack", k_quiet, 16'h0000, 8'h00, 8'h00, 1'b0);
      add_entry("ime_set_2", k_ime, 16'h0000, 8'h01, 8'h01, 1'b0);
      add_entry("dispatch_joypad", k_dispatch, 16'h0000, 8'h00, 8'd4, 1'b0);
      add_entry("ie_clear", k_write, MMIO_IE, 8'h00, 8'h00, 1'b0);
      add_entry("ime_set_3", k_ime, 16'h0000, 8'h01, 8'h01, 1'b0);
      add_entry("quiet_ie_zero", k_quiet, 16'h0000, 8'h00, 8'h00, 1'b0);
      // IME still set so enabling everything starts vblank
      add_entry("ie_enable_all", k_write, MMIO_IE, 8'h1f, 8'h00, 1'b0);
      add_entry("dispatch_vblank", k_dispatch, 16'h0000, 8'h00, 8'd0, 1'b0);
      add_entry("ime_set_4", k_ime, 16'h0000, 8'h01, 8'h01, 1'b0);
      add_entry("dispatch_serial", k_dispatch, 16'h0000, 8'h00, 8'd3, 1'b0);
      add_entry("ime_set_5", k_ime, 16'h0000, 8'h01, 8'h01, 1'b0);
      add_entry("quiet_if_empty", k_quiet, 16'h0000, 8'h00, 8'h00, 1'b0);
      add_entry("ime_reset", k_ime, 16'h0000, 8'h00, 8'h00, 1'b0);
   endtask

   // One strobe cycle with the read result one edge later
   task automatic do_access(input entry_t e, input string name);
      ext_bus_t want;
      logic     outside;
      outside = is_external(e.addr);
      @(posedge clock);
      #2;
      mem_disable   = e.mem_off;
      request.addr  = e.addr;
      request.wdata = (e.kind == k_write) ? e.data : 8'h00;
      request.we    = (e.kind == k_write);
      request.re    = (e.kind == k_read);
      ext_rdata     = (e.kind == k_read) ? e.data : 8'h00;
      want.addr     = e.addr;
      want.wdata    = request.wdata;
      want.we       = request.we && outside && !e.mem_off;
      want.re       = request.re && outside && !e.mem_off;
      #1;
      check_ext(name, want, ext);
      @(posedge clock);
      #2;
      request = '0;
      if (e.kind == k_read) begin
         #1;
         check_flag(name, 1'b1, rdata_valid);
         check_byte(name, e.expected, rdata);
         // Register outputs hold the value just read over the bus
         if (e.addr == MMIO_IE)
            check_bits(name, irq_bits_t'(e.expected), ie_data);
         if (e.addr == MMIO_IF)
            check_bits(name, irq_bits_t'(e.expected), if_data);
      end
   endtask

   task automatic pulse_irq(input entry_t e);
      @(posedge clock);
      #2;
      irq_request = e.data[4:0];
      @(posedge clock);
      #2;
      irq_request = '0;
   endtask

   task automatic pulse_ime(input entry_t e, input string name);
      @(posedge clock);
      #2;
      if (e.data[0])
         ime_set = 1'b1;
      else
         ime_reset = 1'b1;
      @(posedge clock);
      #2;
      ime_set   = 1'b0;
      ime_reset = 1'b0;
      check_flag(name, e.expected[0], ime);
   endtask

   // Outputs sampled mid-cycle on the falling edge
   task automatic expect_dispatch(input entry_t e, input string name);
      int         waited;
      int         edges;
      irq_index_t idx;
      irq_bits_t  mask;
      idx    = irq_index_t'(e.expected);
      mask   = irq_bits_t'(1) << idx;
      waited = 0;
      edges  = 0;
      @(negedge clock);
      while (!pending_level() && waited < 16) begin
         @(negedge clock);
         waited++;
      end
      if (!pending_level()) begin
         flag_error($sformatf("%s: interrupt never became pending", name));
         return;
      end
      // First edge here is the one that samples pending
      while (!vector_valid && edges < 16) begin
         @(negedge clock);
         edges++;
      end
      if (!vector_valid) begin
         flag_error($sformatf("%s: no vector_valid pulse after pending", name));
         return;
      end
      if (edges != DISPATCH_WAIT + 1)
         flag_error($sformatf("ERROR %s dispatch edges expected %0d actual %0d",
                              name, DISPATCH_WAIT + 1, edges));
      check_addr(name, VECTOR_BASE + addr_t'(VECTOR_STEP * int'(e.expected)), vector);
      @(negedge clock);
      check_flag(name, 1'b0, vector_valid);
      check_bits(name, '0, if_data & mask);
      check_flag(name, 1'b0, ime);
   endtask

   task automatic expect_quiet(input string name);
      for (int n = 0; n < 16; n++) begin
         @(negedge clock);
         if (vector_valid)
            flag_error($sformatf("%s: dispatch happened while none was due", name));
      end
   endtask

   initial begin
      reset       = 1'b1;
      request     = '0;
      mem_disable = 1'b0;
      ext_rdata   = '0;
      irq_request = '0;
      ime_set     = 1'b0;
      ime_reset   = 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (2) @(posedge clock);
      #2;
      reset = 1'b0;
      for (int i = 0; i < entries.size(); i++) begin
         test_bad = 1'b0;
         case (entries[i].kind)
            k_write, k_read: do_access(entries[i], names[i]);
            k_irq:           pulse_irq(entries[i]);
            k_ime:           pulse_ime(entries[i], names[i]);
            k_dispatch:      expect_dispatch(entries[i], names[i]);
            default:         expect_quiet(names[i]);
         endcase
         if (test_bad) begin
            failing++;
            $display("FAIL %s", names[i]);
         end else begin
            $display("PASS %s", names[i]);
         end
      end
      $display("Summary: %0d tests, %0d failing, %0d errors", entries.size(), failing, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   // Budget of 20 cycles per table row
   initial begin
      wait (table_ready);
      #(entries.size() * 20 * 20);
      $display("Watchdog timeout, the run did not reach its end");
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

//--- compile.f
verilog/gb80_pkg.sv
verilog/memory_bus.sv
verilog/high_ram.sv
verilog/irq_registers.sv
verilog/dispatch_fsm.sv
verilog/dispatch_timer.sv
verilog/gb80_irq_top.sv
bench/tb_gb80_irq.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the GB80 interrupt subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

log_file=sim.log
fail_text="CHECKS FAILED"

verilator --binary --timing -Wno-fatal --top-module tb_gb80_irq \
   -f compile.f -o tb_gb80_irq
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_gb80_irq > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

# Verdict comes from the log
if grep -q "$fail_text" "$log_file"; then
   echo "Simulation reported failures"
   exit 1
fi

echo "Simulation finished without failures"
exit 0
